/* rtl/arReadSelect.sv */
// Address register read select
module arReadSelect import regSelPkg::*; (
    input  opCode_t     op,
    input  opCode_t     opWb,
    input  biw_t        biw0,
    input  fetchState_t fetchState,
    input  logic        phase2,
    input  logic        rdRdy,
    output regIdx_t     arSelRd1,
    output regIdx_t     arSelRd2
);

    regIdx_t    dstIdx;
    regIdx_t    srcIdx;
    adrMode_t   dstMode;
    adrMode_t   srcMode;
    logic [4:0] exgMode;
    logic       addxDst;
    logic       cmpmDst;
    logic       moveDst;
    logic       spSel;

    // Instructions that address through the ea register field.
    function automatic logic hasEaReg(opCode_t o);
        case (o)
            add, adda, addi, addq, addx, andB, clr, cmp, cmpa, cmpi, cmpm, eor,
            exg, jsr, lea, link, move, movea, orB, sub, suba, subi, subq, subx,
            tst, unlk:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    assign dstIdx  = biw0[11:9];
    assign srcIdx  = biw0[2:0];
    assign dstMode = biw0[8:6];
    assign srcMode = biw0[5:3];
    assign exgMode = biw0[7:3];

    // Selector runs one cycle ahead of the bus cycle.
    always_comb begin
        addxDst = 1'b0;
        if (op == addx || op == subx) begin
            case (fetchState)
                startOp, initExecWb: addxDst = 1'b1;
                calcAeff:            addxDst = !phase2;
                fetchOperand:        addxDst = !phase2 && !rdRdy;  // Destination first.
                default:             addxDst = 1'b0;
            endcase
        end
    end

    assign cmpmDst = op == cmpm && fetchState == fetchOperand && !phase2;

    always_comb begin
        moveDst = 1'b0;
        if (op == move) begin
            case (fetchState)
                fetchMemadr: moveDst = phase2;
                startOp:     moveDst = srcMode < 3'b010 && dstMode != 3'b000;  // Dn, An.
                calcAeff:    moveDst = phase2;
                fetchOperand:
                    moveDst = rdRdy && dstMode == modePreDec && srcMode != modePostInc;
                fetchIdataB1, switchState, initExecWb:
                    moveDst = dstMode != 3'b000;
                fetchAbsLo:  moveDst = dstMode != 3'b000 && !phase2;
                default:     moveDst = 1'b0;
            endcase
        end
    end

    // Stack pointer users.
    always_comb begin
        case (op)
            rts:
                spSel = 1'b1;
            link, jsr:
                spSel = fetchState == startOp || fetchState == initExecWb;
            unlk:
                spSel = fetchState == startOp || fetchState == calcAeff ||
                        fetchState == fetchOperand || opWb == unlk;  // Back-to-back UNLK.
            default:
                spSel = 1'b0;
        endcase
    end

    always_comb begin
        if (addxDst || cmpmDst || moveDst)
            arSelRd1 = dstIdx;
        else if (spSel)
            arSelRd1 = stackPtrIdx;
        else if (hasEaReg(op))
            arSelRd1 = srcIdx;
        else
            arSelRd1 = '0;
    end

    // Second port carries the non-addressing operand.
    always_comb begin
        case (op)
            addq, move, subq, tst: arSelRd2 = srcIdx;
            exg:                   arSelRd2 = (exgMode == exgDataAddr) ? srcIdx : dstIdx;
            adda, cmpa, suba:      arSelRd2 = dstIdx;
            default:               arSelRd2 = '0;
        endcase
    end

endmodule

/* rtl/arUpdateControl.sv */
// Address register increment and decrement
module arUpdateControl import regSelPkg::*; (
    input  opCode_t     op,
    input  biw_t        biw0,
    input  fetchState_t fetchState,
    input  fetchState_t nextFetchState,
    input  adrMode_t    adrMode,
    input  logic        initEntry,
    input  logic        phase2,
    input  logic        aluInit,
    input  logic        rdRdy,
    input  logic        dataRdy,
    input  logic        dataValid,
    output logic        arInc,
    output logic        arDec
);

    adrMode_t dstMode;
    adrMode_t srcMode;
    logic     postInc;
    logic     preDec;
    logic     leavesOperand;
    logic     leavesInitWb;
    logic     entersCalc;
    logic     stackPop;

    // Operations that step (An)+ at ALU start.
    function automatic logic isIncAluOp(opCode_t o);
        case (o)
            add, addi, addq, andB, clr, cmp, cmpi, eor, orB, sub, subi, subq, tst:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // Operations that step -(An) on the way into calcAeff.
    function automatic logic isDecAluOp(opCode_t o);
        case (o)
            add, adda, addi, addq, addx, andB, cmp, cmpa, cmpi, eor, move, movea,
            orB, sub, suba, subi, subq, subx, tst:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    assign dstMode       = biw0[8:6];
    assign srcMode       = biw0[5:3];
    assign postInc       = adrMode == modePostInc;
    assign preDec        = adrMode == modePreDec;
    assign leavesOperand = fetchState == fetchOperand && nextFetchState != fetchOperand;
    assign leavesInitWb  = fetchState == initExecWb && nextFetchState != initExecWb;
    assign entersCalc    = fetchState != calcAeff && nextFetchState == calcAeff;
    assign stackPop      = fetchState == fetchOperand && rdRdy && dataValid;

    always_comb begin
        case (op)
            adda, cmpa, suba:
                arInc = postInc && fetchState == fetchOperand && dataRdy;
            move:
                arInc = (postInc && leavesOperand) ||
                        (dstMode == modePostInc && leavesInitWb);
            movea:
                arInc = postInc && leavesInitWb;
            cmpm, unlk, rts:
                arInc = stackPop;  // Operand read completed.
            default:
                arInc = postInc && aluInit && isIncAluOp(op);
        endcase
    end

    always_comb begin
        if (preDec && entersCalc && isDecAluOp(op)) begin
            arDec = 1'b1;
        end else begin
            case (op)
                jsr, link:
                    arDec = fetchState == startOp && nextFetchState != startOp;  // Push.
                clr:
                    arDec = preDec && initEntry;
                move:
                    // Single step in the first half of switchState.
                    arDec = dstMode == modePreDec &&
                            ((srcMode != modePostInc && initEntry) ||
                             (fetchState == switchState && !phase2));
                default:
                    arDec = 1'b0;
            endcase
        end
    end

endmodule

/* rtl/ctrlRegSel.sv */
// Controller register select
module ctrlRegSel import regSelPkg::*; (
    input  opCode_t      op,
    input  opCode_t      opWb,
    input  biw_t         biw0,
    input  biw_t         biw0Wb,
    input  biw_t         extWord,
    input  fetchState_t  fetchState,
    input  fetchState_t  nextFetchState,
    input  execWbState_t execWbState,
    input  adrMode_t     adrMode,
    input  logic         initEntry,
    input  logic         phase2,
    input  logic         aluInit,
    input  logic         aluBusy,
    input  logic         rdRdy,
    input  logic         dataRdy,
    input  logic         dataValid,
    output regIdx_t      arSelRd1,
    output regIdx_t      arSelRd2,
    output regIdx_t      arSelWr1,
    output regIdx_t      arSelWr2,
    output logic         arInc,
    output logic         arDec,
    output logic         arWr1,
    output logic         arWr2,
    output regIdx_t      drSelRd1,
    output regIdx_t      drSelRd2,
    output regIdx_t      drSelWr1,
    output regIdx_t      drSelWr2,
    output logic         drWr1,
    output logic         drWr2
);

    arReadSelect uArRead (
        .op        (op),
        .opWb      (opWb),
        .biw0      (biw0),
        .fetchState(fetchState),
        .phase2    (phase2),
        .rdRdy     (rdRdy),
        .arSelRd1  (arSelRd1),
        .arSelRd2  (arSelRd2)
    );

    arUpdateControl uArUpdate (
        .op            (op),
        .biw0          (biw0),
        .fetchState    (fetchState),
        .nextFetchState(nextFetchState),
        .adrMode       (adrMode),
        .initEntry     (initEntry),
        .phase2        (phase2),
        .aluInit       (aluInit),
        .rdRdy         (rdRdy),
        .dataRdy       (dataRdy),
        .dataValid     (dataValid),
        .arInc         (arInc),
        .arDec         (arDec)
    );

    drSelect uDrSel (
        .op        (op),
        .biw0      (biw0),
        .extWord   (extWord),
        .fetchState(fetchState),
        .drSelRd1  (drSelRd1),
        .drSelRd2  (drSelRd2),
        .drSelWr1  (drSelWr1),
        .drSelWr2  (drSelWr2)
    );

    // All four write strobes come from one place.
    writebackControl uWb (
        .op            (op),
        .opWb          (opWb),
        .biw0          (biw0),
        .biw0Wb        (biw0Wb),
        .fetchState    (fetchState),
        .nextFetchState(nextFetchState),
        .execWbState   (execWbState),
        .aluBusy       (aluBusy),
        .arSelWr1      (arSelWr1),
        .arSelWr2      (arSelWr2),
        .arWr1         (arWr1),
        .arWr2         (arWr2),
        .drWr1         (drWr1),
        .drWr2         (drWr2)
    );

endmodule

/* rtl/drSelect.sv */
// Data register read and write select
module drSelect import regSelPkg::*; (
    input  opCode_t     op,
    input  biw_t        biw0,
    input  biw_t        extWord,
    input  fetchState_t fetchState,
    output regIdx_t     drSelRd1,
    output regIdx_t     drSelRd2,
    output regIdx_t     drSelWr1,
    output regIdx_t     drSelWr2
);

    regIdx_t    dstIdx;
    regIdx_t    srcIdx;
    regIdx_t    indexIdx;
    logic [4:0] exgMode;
    logic       dirBit;
    logic       dirOp;

    assign dstIdx   = biw0[11:9];
    assign srcIdx   = biw0[2:0];
    assign indexIdx = extWord[14:12];  // Index register of the brief extension.
    assign exgMode  = biw0[7:3];
    assign dirBit   = biw0[8];         // Set when Dn is the source.

    // Two-operand forms with an operand direction bit.
    assign dirOp = op == add || op == sub || op == andB || op == orB;

    always_comb begin
        if (fetchState == fetchExword1) begin
            drSelRd1 = indexIdx;
        end else if ((dirOp || op == eor) && dirBit) begin
            drSelRd1 = dstIdx;
        end else begin
            case (op)
                add, andB, orB, sub, adda, addx, cmp, cmpa:
                    drSelRd1 = srcIdx;
                exg:
                    drSelRd1 = (exgMode == exgDataAddr) ? dstIdx : srcIdx;
                move, movea, suba, subx:
                    drSelRd1 = srcIdx;
                default:
                    drSelRd1 = '0;
            endcase
        end
    end

    always_comb begin
        if (op == addx || op == subx)
            drSelRd2 = dstIdx;
        else if (dirOp && dirBit)
            drSelRd2 = srcIdx;
        else begin
            case (op)
                add, cmp, sub, andB, orB, exg:
                    drSelRd2 = dstIdx;
                addi, addq, cmpi, eor, subi, subq, tst:
                    drSelRd2 = srcIdx;  // Dn as the ea operand.
                default:
                    drSelRd2 = '0;
            endcase
        end
    end

    // Register destination forms write Dn from bits 11..9.
    always_comb begin
        case (op)
            addx, subx, add, sub, andB, orB, exg, move, moveq:
                drSelWr1 = dstIdx;
            default:
                drSelWr1 = srcIdx;
        endcase
    end

    assign drSelWr2 = srcIdx;  // Second EXG register.

endmodule

/* rtl/regSelPkg.sv */
// Register select shared types
package regSelPkg;

    // Decoded integer instructions.
    typedef enum logic [6:0] {
        add,
        adda,
        addi,
        addq,
        addx,
        sub,
        suba,
        subi,
        subq,
        subx,
        cmp,
        cmpa,
        cmpi,
        cmpm,
        andB,
        orB,
        eor,
        tst,
        clr,
        move,
        movea,
        moveq,
        exg,
        lea,
        link,
        unlk,
        jsr,
        rts
    } opCode_t;

    // Fetch FSM of the parent controller.
    typedef enum logic [4:0] {
        startOp      = 5'd0,
        calcAeff     = 5'd1,
        fetchDispl   = 5'd2,
        fetchExword1 = 5'd3,
        fetchAbsLo   = 5'd9,
        fetchIdataB1 = 5'd11,
        fetchMemadr  = 5'd12,
        fetchOperand = 5'd13,
        initExecWb   = 5'd14,
        switchState  = 5'd16
    } fetchState_t;

    // Execute and writeback FSM.
    typedef enum logic [2:0] {
        idle        = 3'd0,
        execute     = 3'd1,
        adrPipeline = 3'd2,
        writeback   = 3'd3,
        writeDest   = 3'd4
    } execWbState_t;

    typedef logic [2:0]  regIdx_t;   // Register number.
    typedef logic [2:0]  adrMode_t;  // Effective address mode field.
    typedef logic [15:0] biw_t;      // Instruction or extension word.

    localparam adrMode_t modePostInc = 3'd3;  // (An)+
    localparam adrMode_t modePreDec  = 3'd4;  // -(An)

    localparam regIdx_t stackPtrIdx = 3'd7;  // A7 is the active SP.

    // EXG operation mode field, biw bits 7..3.
    localparam logic [4:0] exgDataAddr = 5'b10001;  // Dn with An.
    localparam logic [4:0] exgAddrAddr = 5'b01001;  // An with An.
    localparam logic [4:0] exgDataData = 5'b01000;  // Dn with Dn.

endpackage

/* rtl/writebackControl.sv */
// Register write indices and strobes
module writebackControl import regSelPkg::*; (
    input  opCode_t      op,
    input  opCode_t      opWb,
    input  biw_t         biw0,
    input  biw_t         biw0Wb,
    input  fetchState_t  fetchState,
    input  fetchState_t  nextFetchState,
    input  execWbState_t execWbState,
    input  logic         aluBusy,
    output regIdx_t      arSelWr1,
    output regIdx_t      arSelWr2,
    output logic         arWr1,
    output logic         arWr2,
    output logic         drWr1,
    output logic         drWr2
);

    logic [4:0] exgMode;
    logic [4:0] exgModeWb;
    adrMode_t   dstModeWb;
    logic       inWriteback;
    logic       exgWb;

    assign exgMode     = biw0[7:3];
    assign exgModeWb   = biw0Wb[7:3];
    assign dstModeWb   = biw0Wb[5:3];
    assign inWriteback = execWbState == writeback;
    assign exgWb       = inWriteback && opWb == exg;

    always_comb begin
        case (op)
            addq, subq, link:
                arSelWr1 = biw0[2:0];
            exg:
                arSelWr1 = (exgMode == exgDataAddr) ? biw0[2:0] : biw0[11:9];
            unlk:
                arSelWr1 = (fetchState == startOp) ? stackPtrIdx : biw0[11:9];
            default:
                arSelWr1 = biw0[11:9];  // ADDA, LEA, MOVEA, SUBA.
        endcase
    end

    assign arSelWr2 = biw0[2:0];  // EXG and UNLK.

    always_comb begin
        if (op == link && fetchState == initExecWb && !aluBusy) begin
            arWr1 = 1'b1;
        end else if (op == unlk && fetchState == switchState &&
                     nextFetchState != switchState) begin
            arWr1 = 1'b1;  // Frame pointer into SP.
        end else if (inWriteback) begin
            case (opWb)
                adda, suba, lea, movea:
                    arWr1 = 1'b1;
                addq, subq:
                    arWr1 = dstModeWb == 3'b001;  // An destination.
                exg:
                    arWr1 = exgModeWb == exgAddrAddr || exgModeWb == exgDataAddr;
                default:
                    arWr1 = 1'b0;
            endcase
        end else begin
            arWr1 = 1'b0;
        end
    end

    // Popped frame pointer, or second An of EXG.
    assign arWr2 = inWriteback && (opWb == unlk || (opWb == exg && exgModeWb == exgAddrAddr));

    always_comb begin
        if (exgWb && exgModeWb == exgDataAddr)
            drWr1 = 1'b1;
        else if (arWr1 || arWr2)
            drWr1 = 1'b0;  // Address write locks out Dn.
        else
            drWr1 = inWriteback;
    end

    assign drWr2 = exgWb && exgModeWb == exgDataData;

endmodule

/* sources.f */
+incdir+verification
rtl/regSelPkg.sv
rtl/arReadSelect.sv
rtl/arUpdateControl.sv
rtl/drSelect.sv
rtl/writebackControl.sv
rtl/ctrlRegSel.sv
verification/ctrlRegSelTb.sv

/* verification/regSelCases.svh */
// Register select case table
`ifndef REG_SEL_CASES_SVH
`define REG_SEL_CASES_SVH

// Columns: name, op, opWb, biw0, biw0Wb, extWord, fetchState, nextFetchState,
// execWbState, adrMode, flags, expected arSel, drSel and strobes.
task automatic loadCases();
    addCase("addxStart", addx, tst, 16'hD503, 16'h0000, 16'h0000,
        startOp, startOp, idle, 3'd0, 7'b0000000, 12'o2023, 12'o3223, 6'b000000);
    addCase("addxOperand", addx, tst, 16'hD503, 16'h0000, 16'h0000,
        fetchOperand, fetchOperand, idle, 3'd0, 7'b0000000, 12'o2023, 12'o3223, 6'b000000);
    addCase("addxOperandRdy", addx, tst, 16'hD503, 16'h0000, 16'h0000,
        fetchOperand, fetchOperand, idle, 3'd0, 7'b0000100, 12'o3023, 12'o3223, 6'b000000);
    addCase("rtsStart", rts, tst, 16'h4E75, 16'h0000, 16'h0000,
        startOp, startOp, idle, 3'd0, 7'b0000000, 12'o7075, 12'o0055, 6'b000000);
    addCase("rtsPop", rts, tst, 16'h4E75, 16'h0000, 16'h0000,
        fetchOperand, fetchOperand, idle, 3'd0, 7'b0000101, 12'o7075, 12'o0055, 6'b100000);
    addCase("unlkCalc", unlk, tst, 16'h4E5E, 16'h0000, 16'h0000,
        calcAeff, calcAeff, idle, 3'd0, 7'b0000000, 12'o7076, 12'o0066, 6'b000000);
    addCase("addDirClear", add, tst, 16'hD641, 16'h0000, 16'h0000,
        startOp, startOp, idle, 3'd0, 7'b0000000, 12'o1031, 12'o1331, 6'b000000);
    addCase("addDirSet", add, tst, 16'hD741, 16'h0000, 16'h0000,
        startOp, startOp, idle, 3'd0, 7'b0000000, 12'o1031, 12'o3131, 6'b000000);
    addCase("addPostInc", add, tst, 16'hD65A, 16'h0000, 16'h0000,
        initExecWb, initExecWb, idle, 3'd3, 7'b0010000, 12'o2032, 12'o2332, 6'b100000);
    addCase("cmpmRead", cmpm, tst, 16'hB70C, 16'h0000, 16'h0000,
        fetchOperand, fetchOperand, idle, 3'd3, 7'b0000101, 12'o3034, 12'o0044, 6'b100000);
    addCase("cmpmNoData", cmpm, tst, 16'hB70C, 16'h0000, 16'h0000,
        fetchOperand, fetchOperand, idle, 3'd3, 7'b0000100, 12'o3034, 12'o0044, 6'b000000);
    addCase("subPreDec", sub, tst, 16'h9222, 16'h0000, 16'h0000,
        startOp, calcAeff, idle, 3'd4, 7'b0000000, 12'o2012, 12'o2112, 6'b010000);
    addCase("linkPush", link, tst, 16'h4E56, 16'h0000, 16'h0000,
        startOp, fetchDispl, idle, 3'd0, 7'b0000000, 12'o7066, 12'o0066, 6'b010000);
    addCase("linkInitWb", link, tst, 16'h4E56, 16'h0000, 16'h0000,
        initExecWb, initExecWb, idle, 3'd0, 7'b0000000, 12'o7066, 12'o0066, 6'b001000);
    addCase("linkAluBusy", link, tst, 16'h4E56, 16'h0000, 16'h0000,
        initExecWb, initExecWb, idle, 3'd0, 7'b0001000, 12'o7066, 12'o0066, 6'b000000);
    addCase("addaWb", adda, adda, 16'hD7C2, 16'hD7C2, 16'h0000,
        startOp, startOp, writeback, 3'd0, 7'b0000000, 12'o2332, 12'o2022, 6'b001000);
    addCase("addaExec", adda, adda, 16'hD7C2, 16'hD7C2, 16'h0000,
        startOp, startOp, execute, 3'd0, 7'b0000000, 12'o2332, 12'o2022, 6'b000000);
    addCase("leaWb", lea, lea, 16'h49D1, 16'h49D1, 16'h0000,
        startOp, startOp, writeback, 3'd0, 7'b0000000, 12'o1041, 12'o0011, 6'b001000);
    addCase("leaExec", lea, lea, 16'h49D1, 16'h49D1, 16'h0000,
        startOp, startOp, execute, 3'd0, 7'b0000000, 12'o1041, 12'o0011, 6'b000000);
    addCase("moveaWb", movea, movea, 16'h2445, 16'h2445, 16'h0000,
        startOp, startOp, writeback, 3'd0, 7'b0000000, 12'o5025, 12'o5055, 6'b001000);
    addCase("moveaExec", movea, movea, 16'h2445, 16'h2445, 16'h0000,
        startOp, startOp, execute, 3'd0, 7'b0000000, 12'o5025, 12'o5055, 6'b000000);
    addCase("exgDataData", exg, exg, 16'hC343, 16'hC343, 16'h0000,
        startOp, startOp, writeback, 3'd0, 7'b0000000, 12'o3113, 12'o3113, 6'b000011);
    addCase("exgAddrAddr", exg, exg, 16'hC34B, 16'hC34B, 16'h0000,
        startOp, startOp, writeback, 3'd0, 7'b0000000, 12'o3113, 12'o3113, 6'b001100);
    addCase("exgDataAddr", exg, exg, 16'hC38B, 16'hC38B, 16'h0000,
        startOp, startOp, writeback, 3'd0, 7'b0000000, 12'o3333, 12'o1113, 6'b001010);
    addCase("indexFetch", add, tst, 16'hD641, 16'h0000, 16'h6000,
        fetchExword1, fetchExword1, idle, 3'd0, 7'b0000000, 12'o1031, 12'o6331, 6'b000000);
endtask

`endif

/* verification/ctrlRegSelTb.sv */
// Register select testbench
module ctrlRegSelTb import regSelPkg::*; ();

    localparam int clkPeriod  = 40;
    localparam int driveDelay = 5;
    localparam int sweepLen   = 200;

    // One table entry, expected selects packed as octal digits.
    typedef struct packed {
        opCode_t      op;
        opCode_t      opWb;
        biw_t         biw0;
        biw_t         biw0Wb;
        biw_t         extWord;
        fetchState_t  fetchState;
        fetchState_t  nextFetchState;
        execWbState_t execWbState;
        adrMode_t     adrMode;
        logic [6:0]   flags;    // initEntry phase2 aluInit aluBusy rdRdy dataRdy dataValid.
        logic [11:0]  arSel;    // Rd1 Rd2 Wr1 Wr2.
        logic [11:0]  drSel;    // Rd1 Rd2 Wr1 Wr2.
        logic [5:0]   strobes;  // arInc arDec arWr1 arWr2 drWr1 drWr2.
    } regSelCase_t;

    logic         clk;
    logic         reset;
    opCode_t      op;
    opCode_t      opWb;
    biw_t         biw0;
    biw_t         biw0Wb;
    biw_t         extWord;
    fetchState_t  fetchState;
    fetchState_t  nextFetchState;
    execWbState_t execWbState;
    adrMode_t     adrMode;
    logic         initEntry, phase2, aluInit, aluBusy, rdRdy, dataRdy, dataValid;
    regIdx_t      arSelRd1, arSelRd2, arSelWr1, arSelWr2;
    regIdx_t      drSelRd1, drSelRd2, drSelWr1, drSelWr2;
    logic         arInc, arDec, arWr1, arWr2, drWr1, drWr2;

    regSelCase_t  cases[$];
    string        caseNames[$];

    ctrlRegSel uut (.*);

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    task automatic addCase(string name, opCode_t o, opCode_t oWb, biw_t w0, biw_t w0Wb,
                           biw_t ext, fetchState_t fs, fetchState_t nfs, execWbState_t ews,
                           adrMode_t mode, logic [6:0] flags, logic [11:0] arSel,
                           logic [11:0] drSel, logic [5:0] strobes);
        caseNames.push_back(name);
        cases.push_back({o, oWb, w0, w0Wb, ext, fs, nfs, ews, mode, flags, arSel, drSel,
                         strobes});
    endtask

    `include "regSelCases.svh"

    task automatic applyIdle();
        op             = tst;
        opWb           = tst;
        biw0           = '0;
        biw0Wb         = '0;
        extWord        = '0;
        fetchState     = startOp;
        nextFetchState = startOp;
        execWbState    = idle;
        adrMode        = '0;
        {initEntry, phase2, aluInit, aluBusy, rdRdy, dataRdy, dataValid} = '0;
    endtask

    task automatic applyCase(regSelCase_t c);
        op             = c.op;
        opWb           = c.opWb;
        biw0           = c.biw0;
        biw0Wb         = c.biw0Wb;
        extWord        = c.extWord;
        fetchState     = c.fetchState;
        nextFetchState = c.nextFetchState;
        execWbState    = c.execWbState;
        adrMode        = c.adrMode;
        {initEntry, phase2, aluInit, aluBusy, rdRdy, dataRdy, dataValid} = c.flags;
    endtask

    task automatic checkValue(string what, logic [15:0] expected, logic [15:0] actual);
        if (actual !== expected) begin
            $display("ERR %s: expected %0o, actual %0o", what, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "Output mismatch");
        end
    endtask

    task automatic verifyCase(string name, regSelCase_t c);
        checkValue({name, " arSel"}, c.arSel, {arSelRd1, arSelRd2, arSelWr1, arSelWr2});
        checkValue({name, " drSel"}, c.drSel, {drSelRd1, drSelRd2, drSelWr1, drSelWr2});
        checkValue({name, " strobes"}, c.strobes, {arInc, arDec, arWr1, arWr2, drWr1, drWr2});
    endtask

    // Bound derived from the number of applied cycles.
    initial begin
        int timeLimit;
        #1;
        timeLimit = (cases.size() + sweepLen + 20) * clkPeriod;
        #(timeLimit);
        $display("Timeout: the stimulus did not finish in the expected time");
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        biw_t word;
        void'($urandom(32'h55d0d6bb));
        reset = 1'b1;
        applyIdle();
        loadCases();
        repeat (9) @(posedge clk);
        @(negedge clk);
        checkValue("reset writes", 4'b0000, {arWr1, arWr2, drWr1, drWr2});
        @(posedge clk);
        #driveDelay reset = 1'b0;

        for (int i = 0; i < cases.size(); i++) begin
            @(posedge clk);
            #driveDelay applyCase(cases[i]);
            @(negedge clk);
            verifyCase(caseNames[i], cases[i]);
        end

        // ADD in writeback with random words.
        for (int n = 0; n < sweepLen; n++) begin
            @(posedge clk);
            #driveDelay;
            word        = biw_t'($urandom);
            applyIdle();
            op          = add;
            opWb        = add;
            biw0        = word;
            biw0Wb      = word;
            execWbState = writeback;
            @(negedge clk);
            checkValue("sweep arSelWr2", word[2:0], arSelWr2);
            checkValue("sweep drSelWr2", word[2:0], drSelWr2);
            checkValue("sweep drWr1", 1'b1, drWr1);
            checkValue("sweep arWr1", 1'b0, arWr1);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule
